// File: verilog/cp0_addr_pkg.sv
`default_nettype none

package cp0_addr_pkg;

    // ------------------------------------------------------------------
    // Address and data widths
    // ------------------------------------------------------------------
    // Address is {register number, select}
    localparam int CP0_ADDR_W = 8;
    localparam int CP0_DATA_W = 32;

    // ------------------------------------------------------------------
    // Register addresses, {rd[4:0], sel[2:0]}
    // ------------------------------------------------------------------
    localparam logic [CP0_ADDR_W-1:0] ADDR_BADVADDR = 8'h40;
    localparam logic [CP0_ADDR_W-1:0] ADDR_COUNT    = 8'h48;
    localparam logic [CP0_ADDR_W-1:0] ADDR_COMPARE  = 8'h58;
    localparam logic [CP0_ADDR_W-1:0] ADDR_STATUS   = 8'h60;
    localparam logic [CP0_ADDR_W-1:0] ADDR_CAUSE    = 8'h68;
    localparam logic [CP0_ADDR_W-1:0] ADDR_EPC      = 8'h70;
    // PRId and EBase share register 15
    localparam logic [CP0_ADDR_W-1:0] ADDR_PRID     = 8'h78;
    localparam logic [CP0_ADDR_W-1:0] ADDR_EBASE    = 8'h79;
    localparam logic [CP0_ADDR_W-1:0] ADDR_CONFIG0  = 8'h80;

endpackage

`default_nettype wire

// File: verilog/cp0_exc_pkg.sv
`default_nettype none

package cp0_exc_pkg;

    // ------------------------------------------------------------------
    // Exception codes, as carried on the exception strobe
    // ------------------------------------------------------------------
    localparam logic [4:0] EXC_INT  = 5'h00;
    localparam logic [4:0] EXC_MOD  = 5'h01;
    localparam logic [4:0] EXC_TLBL = 5'h02;
    localparam logic [4:0] EXC_TLBS = 5'h03;
    localparam logic [4:0] EXC_ADEL = 5'h04;
    localparam logic [4:0] EXC_ADES = 5'h05;
    localparam logic [4:0] EXC_CPU  = 5'h0b;
    // Return from exception, not an architectural ExcCode
    localparam logic [4:0] EXC_ERET = 5'h1f;

    // Kseg0 attribute treated as cached
    localparam logic [2:0] K0_CACHEABLE = 3'd3;

    // ------------------------------------------------------------------
    // Field positions
    // ------------------------------------------------------------------
    localparam int STATUS_BEV_BIT = 22;
    localparam int CAUSE_TI_BIT   = 30;

endpackage

`default_nettype wire

// File: verilog/cp0_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_timer
    import cp0_addr_pkg::*;
#(
    parameter int COUNT_DIV_LOG2 = 1
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   we_i,
    input  wire  [CP0_ADDR_W-1:0] waddr_i,
    input  wire  [CP0_DATA_W-1:0] wdata_i,
    output logic [CP0_DATA_W-1:0] count_o,
    output logic [CP0_DATA_W-1:0] compare_o,
    output logic                  timer_irq_o
);

    // Prescaler needs at least one bit
    localparam int PRE_W = (COUNT_DIV_LOG2 > 0) ? COUNT_DIV_LOG2 : 1;

    logic [PRE_W-1:0]      prescale_q;
    logic [CP0_DATA_W-1:0] count_q;
    logic [CP0_DATA_W-1:0] compare_q;
    logic                  compare_armed_q;
    logic                  irq_q;
    logic                  count_tick;
    logic                  count_we;
    logic                  compare_we;

    // Own write decode
    assign count_we   = we_i && (waddr_i == ADDR_COUNT);
    assign compare_we = we_i && (waddr_i == ADDR_COMPARE);

    // One tick per 2^COUNT_DIV_LOG2 cycles
    assign count_tick = (COUNT_DIV_LOG2 == 0) || (&prescale_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prescale_q <= '0;
            count_q    <= '0;
        end else begin
            prescale_q <= prescale_q + 1'b1;
            // Software load wins over the tick
            if (count_we) begin
                count_q <= wdata_i;
            end else if (count_tick) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (compare_we) begin
            compare_q <= wdata_i;
        end
    end

    // Sticky flag, Compare write acks it
    // No match until Compare is loaded once
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            compare_armed_q <= 1'b0;
            irq_q           <= 1'b0;
        end else if (compare_we) begin
            compare_armed_q <= 1'b1;
            irq_q           <= 1'b0;
        end else if (compare_armed_q && (count_q == compare_q)) begin
            irq_q <= 1'b1;
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: verilog/cp0_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_regs
    import cp0_addr_pkg::*;
    import cp0_exc_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire  [5:0]            int_i,
    input  wire                   timer_irq_i,
    // Write strobe
    input  wire                   we_i,
    input  wire  [CP0_ADDR_W-1:0] waddr_i,
    input  wire  [CP0_DATA_W-1:0] wdata_i,
    // Exception strobe
    input  wire                   exc_valid_i,
    input  wire  [4:0]            exc_code_i,
    input  wire  [CP0_DATA_W-1:0] exc_pc_i,
    input  wire  [CP0_DATA_W-1:0] exc_badaddr_i,
    input  wire                   exc_bd_i,
    input  wire                   exc_cpux_i,
    // Architectural words
    output logic [CP0_DATA_W-1:0] status_o,
    output logic [CP0_DATA_W-1:0] cause_o,
    output logic [CP0_DATA_W-1:0] epc_o,
    output logic [CP0_DATA_W-1:0] badvaddr_o,
    output logic [CP0_DATA_W-1:0] ebase_o,
    output logic [CP0_DATA_W-1:0] config0_o,
    output logic                  uncache_o
);

    logic                  status_we, cause_we, epc_we, ebase_we, config0_we;
    logic                  exc_normal, exc_eret, exc_take, exc_badv, exc_cpu;
    logic                  status_cu0_q, status_bev_q, status_um_q;
    logic                  status_exl_q, status_ie_q;
    logic [7:0]            status_im_q;
    logic                  cause_bd_q, cause_iv_q;
    logic [1:0]            cause_ce_q, cause_ip_sw_q;
    logic [5:0]            cause_ip_hw_q;
    logic [4:0]            cause_exc_q;
    logic [CP0_DATA_W-1:0] epc_q, badvaddr_q, cause_w;
    logic [17:0]           ebase_base_q;
    logic [2:0]            config_k0_q;

    // ------------------------------------------------------------------
    // Write decode and exception classification
    // ------------------------------------------------------------------
    assign status_we  = we_i && (waddr_i == ADDR_STATUS);
    assign cause_we   = we_i && (waddr_i == ADDR_CAUSE);
    assign epc_we     = we_i && (waddr_i == ADDR_EPC);
    assign ebase_we   = we_i && (waddr_i == ADDR_EBASE);
    assign config0_we = we_i && (waddr_i == ADDR_CONFIG0);

    assign exc_eret   = exc_valid_i && (exc_code_i == EXC_ERET);
    assign exc_normal = exc_valid_i && (exc_code_i != EXC_ERET);
    // Nested exceptions keep EPC, BD and ExcCode
    assign exc_take   = exc_normal && !status_exl_q;
    // TLB and address errors report the faulting address
    assign exc_badv   = exc_valid_i && (exc_code_i inside {EXC_MOD, EXC_TLBL, EXC_TLBS,
                                                           EXC_ADEL, EXC_ADES});
    assign exc_cpu    = exc_valid_i && (exc_code_i == EXC_CPU);

    // ------------------------------------------------------------------
    // Status
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_cu0_q <= 1'b0;
            status_bev_q <= 1'b1;
            status_im_q  <= '0;
            status_um_q  <= 1'b0;
            status_ie_q  <= 1'b0;
        end else if (status_we) begin
            status_cu0_q <= wdata_i[28];
            status_bev_q <= wdata_i[STATUS_BEV_BIT];
            status_im_q  <= wdata_i[15:8];
            status_um_q  <= wdata_i[4];
            status_ie_q  <= wdata_i[0];
        end
    end

    // Exception events override software
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_exl_q <= 1'b0;
        end else if (exc_eret) begin
            status_exl_q <= 1'b0;
        end else if (exc_normal) begin
            status_exl_q <= 1'b1;
        end else if (status_we) begin
            status_exl_q <= wdata_i[1];
        end
    end

    // ------------------------------------------------------------------
    // Cause
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cause_bd_q    <= 1'b0;
            cause_exc_q   <= '0;
            cause_ce_q    <= '0;
            cause_iv_q    <= 1'b0;
            cause_ip_sw_q <= '0;
            cause_ip_hw_q <= '0;
        end else begin
            // IP7 shares the timer line
            cause_ip_hw_q <= {int_i[5] | timer_irq_i, int_i[4:0]};
            if (exc_take) begin
                cause_bd_q  <= exc_bd_i;
                cause_exc_q <= exc_code_i;
            end
            if (exc_cpu) begin
                cause_ce_q <= {1'b0, exc_cpux_i};
            end
            if (cause_we) begin
                cause_iv_q    <= wdata_i[23];
                cause_ip_sw_q <= wdata_i[9:8];
            end
        end
    end

    always_comb begin
        cause_w               = '0;
        cause_w[31]           = cause_bd_q;
        cause_w[CAUSE_TI_BIT] = timer_irq_i;
        cause_w[29:28]        = cause_ce_q;
        cause_w[23]           = cause_iv_q;
        cause_w[15:10]        = cause_ip_hw_q;
        cause_w[9:8]          = cause_ip_sw_q;
        cause_w[6:2]          = cause_exc_q;
    end

    // ------------------------------------------------------------------
    // EPC, BadVAddr, EBase, Config0
    // ------------------------------------------------------------------
    // Delay slot faults restart at the branch
    always_ff @(posedge clk) begin
        if (exc_take) begin
            epc_q <= exc_bd_i ? (exc_pc_i - 32'd4) : exc_pc_i;
        end else if (epc_we) begin
            epc_q <= wdata_i;
        end
    end

    // Read only, loaded even when EXL is set
    always_ff @(posedge clk) begin
        if (exc_badv) begin
            badvaddr_q <= exc_badaddr_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ebase_base_q <= '0;
            config_k0_q  <= K0_CACHEABLE;
        end else begin
            if (ebase_we) begin
                ebase_base_q <= wdata_i[29:12];
            end
            if (config0_we) begin
                config_k0_q <= wdata_i[2:0];
            end
        end
    end

    // Output words
    assign status_o   = {3'b000, status_cu0_q, 5'b0, status_bev_q, 6'b0,
                         status_im_q, 3'b0, status_um_q, 2'b0, status_exl_q, status_ie_q};
    assign cause_o    = cause_w;
    assign epc_o      = epc_q;
    assign badvaddr_o = badvaddr_q;
    // Bits 31:30 fixed at kseg0/kseg1, CPUNum 0
    assign ebase_o    = {2'b10, ebase_base_q, 12'b0};
    // No Config1, little endian, fixed mapping MMU
    assign config0_o  = {1'b0, 15'b0, 1'b0, 2'b00, 3'b000, 3'b011, 3'b000, 1'b0, config_k0_q};
    assign uncache_o  = (config_k0_q != K0_CACHEABLE);

endmodule

`default_nettype wire

// File: verilog/cp0_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_read_mux
    import cp0_addr_pkg::*;
#(
    parameter logic [31:0] PRID_VALUE = 32'h0001_8000
) (
    input  wire  [CP0_ADDR_W-1:0] raddr_i,
    input  wire  [CP0_DATA_W-1:0] count_i,
    input  wire  [CP0_DATA_W-1:0] compare_i,
    input  wire  [CP0_DATA_W-1:0] status_i,
    input  wire  [CP0_DATA_W-1:0] cause_i,
    input  wire  [CP0_DATA_W-1:0] epc_i,
    input  wire  [CP0_DATA_W-1:0] badvaddr_i,
    input  wire  [CP0_DATA_W-1:0] ebase_i,
    input  wire  [CP0_DATA_W-1:0] config0_i,
    output logic [CP0_DATA_W-1:0] rdata_o
);

    // ------------------------------------------------------------------
    // Combinational read, same cycle as the address
    // ------------------------------------------------------------------
    always_comb begin
        case (raddr_i)
            ADDR_BADVADDR: rdata_o = badvaddr_i;
            ADDR_COUNT:    rdata_o = count_i;
            ADDR_COMPARE:  rdata_o = compare_i;
            ADDR_STATUS:   rdata_o = status_i;
            ADDR_CAUSE:    rdata_o = cause_i;
            ADDR_EPC:      rdata_o = epc_i;
            // Constant ID word
            ADDR_PRID:     rdata_o = PRID_VALUE;
            ADDR_EBASE:    rdata_o = ebase_i;
            ADDR_CONFIG0:  rdata_o = config0_i;
            // Unmapped registers
            default:       rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cp0_top.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_top
    import cp0_addr_pkg::*;
#(
    parameter int          COUNT_DIV_LOG2 = 1,
    parameter logic [31:0] PRID_VALUE     = 32'h0001_8000
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire  [5:0]            int_i,
    input  wire                   we_i,
    input  wire  [CP0_ADDR_W-1:0] waddr_i,
    input  wire  [CP0_DATA_W-1:0] wdata_i,
    input  wire                   exc_valid_i,
    input  wire  [4:0]            exc_code_i,
    input  wire  [CP0_DATA_W-1:0] exc_pc_i,
    input  wire  [CP0_DATA_W-1:0] exc_badaddr_i,
    input  wire                   exc_bd_i,
    input  wire                   exc_cpux_i,
    input  wire  [CP0_ADDR_W-1:0] raddr_i,
    output logic [CP0_DATA_W-1:0] rdata_o,
    output logic [CP0_DATA_W-1:0] status_o,
    output logic [CP0_DATA_W-1:0] cause_o,
    output logic [CP0_DATA_W-1:0] epc_o,
    output logic [CP0_DATA_W-1:0] ebase_o,
    output logic                  uncache_o
);

    logic [CP0_DATA_W-1:0] count_w, compare_w, badvaddr_w, config0_w;
    logic                  timer_irq_w;

    // Timer, source of the interrupt event
    cp0_timer #(
        .COUNT_DIV_LOG2 (COUNT_DIV_LOG2)
    ) i_cp0_timer (
        .clk, .arst_n_i, .we_i, .waddr_i, .wdata_i,
        .count_o     (count_w),
        .compare_o   (compare_w),
        .timer_irq_o (timer_irq_w)
    );

    // Architectural state
    cp0_regs i_cp0_regs (
        .clk, .arst_n_i, .int_i, .we_i, .waddr_i, .wdata_i,
        .timer_irq_i (timer_irq_w),
        .exc_valid_i, .exc_code_i, .exc_pc_i, .exc_badaddr_i, .exc_bd_i, .exc_cpux_i,
        .status_o, .cause_o, .epc_o, .ebase_o, .uncache_o,
        .badvaddr_o  (badvaddr_w),
        .config0_o   (config0_w)
    );

    // Read port
    cp0_read_mux #(
        .PRID_VALUE (PRID_VALUE)
    ) i_cp0_read_mux (
        .raddr_i, .rdata_o,
        .count_i (count_w), .compare_i (compare_w),
        .status_i (status_o), .cause_i (cause_o), .epc_i (epc_o),
        .badvaddr_i (badvaddr_w), .ebase_i (ebase_o), .config0_i (config0_w)
    );

endmodule

`default_nettype wire

// File: sim/cp0_props.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_props #(
    // Enables the set check
    parameter bit CHECK_SET = 1'b1
) (
    input wire clk,
    input wire arst_n_i,
    // Event that must set the flag
    input wire set_i,
    // Event that must clear the flag
    input wire clr_i,
    input wire flag_i
);

    // ------------------------------------------------------------------
    // Flag follows its events one cycle later
    // ------------------------------------------------------------------
    if (CHECK_SET) begin : g_set
        a_flag_set: assert property (@(posedge clk) disable iff (!arst_n_i)
            (set_i && !clr_i) |=> flag_i)
            else $error("flag not set one cycle after its set event");
    end

    a_flag_clr: assert property (@(posedge clk) disable iff (!arst_n_i)
        clr_i |=> !flag_i)
        else $error("flag still set one cycle after its clear event");

endmodule

// EXL set by a taken exception, cleared by a return
bind cp0_regs cp0_props i_exl_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .set_i    (exc_valid_i && (exc_code_i != cp0_exc_pkg::EXC_ERET) && !status_exl_q),
    .clr_i    (exc_valid_i && (exc_code_i == cp0_exc_pkg::EXC_ERET)),
    .flag_i   (status_exl_q)
);

// Timer flag acked by a Compare write
bind cp0_timer cp0_props #(
    .CHECK_SET (1'b0)
) i_irq_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .set_i    (1'b0),
    .clr_i    (we_i && (waddr_i == cp0_addr_pkg::ADDR_COMPARE)),
    .flag_i   (irq_q)
);

`default_nettype wire

// File: sim/tb_cp0.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cp0
    import cp0_addr_pkg::*;
    import cp0_exc_pkg::*;
();

    localparam int          DIV_LOG2   = 1;
    localparam logic [31:0] PRID       = 32'h0001_9300;
    localparam int          POLL_LIMIT = 64;

    // Row operations
    localparam int OP_WR   = 0;
    localparam int OP_EXC  = 1;
    localparam int OP_RD   = 2;
    localparam int OP_POLL = 3;
    localparam int OP_INT  = 4;
    localparam int OP_UNC  = 5;

    logic                  clk;
    logic                  arst_n_i;
    logic [5:0]            int_i;
    logic                  we_i;
    logic [CP0_ADDR_W-1:0] waddr_i;
    logic [31:0]           wdata_i;
    logic                  exc_valid_i;
    logic [4:0]            exc_code_i;
    logic [31:0]           exc_pc_i, exc_badaddr_i;
    logic                  exc_bd_i, exc_cpux_i;
    logic [CP0_ADDR_W-1:0] raddr_i;
    logic [31:0]           rdata_o, status_o, cause_o, epc_o, ebase_o;
    logic                  uncache_o;

    // Stimulus table, one entry per row in each queue
    // ctl holds {bd, cpux, code} for exception rows
    string       name_q[$];
    int          op_q[$];
    logic [7:0]  addr_q[$];
    logic [31:0] data_q[$], bad_q[$], mask_q[$], exp_q[$];
    logic [6:0]  ctl_q[$];

    integer      seed;
    logic [31:0] count_n;
    logic [31:0] got;
    logic        row_ok;
    int          pass_cnt, fail_cnt;

    cp0_top #(
        .COUNT_DIV_LOG2 (DIV_LOG2),
        .PRID_VALUE     (PRID)
    ) i_cp0_top (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // Row access and bus tasks
    // ------------------------------------------------------------------
    task automatic add_row(input string n, input int op, input logic [7:0] a,
                           input logic [31:0] d, input logic [31:0] bad,
                           input logic [6:0] ctl, input logic [31:0] m,
                           input logic [31:0] e);
        name_q.push_back(n);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        bad_q.push_back(bad);
        ctl_q.push_back(ctl);
        mask_q.push_back(m);
        exp_q.push_back(e);
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
        @(posedge clk);
        we_i    <= 1'b1;
        waddr_i <= a;
        wdata_i <= d;
        @(posedge clk);
        we_i    <= 1'b0;
    endtask

    // Single cycle exception strobe
    task automatic raise_exc(input int idx);
        @(posedge clk);
        exc_valid_i   <= 1'b1;
        exc_code_i    <= ctl_q[idx][4:0];
        exc_cpux_i    <= ctl_q[idx][5];
        exc_bd_i      <= ctl_q[idx][6];
        exc_pc_i      <= data_q[idx];
        exc_badaddr_i <= bad_q[idx];
        @(posedge clk);
        exc_valid_i   <= 1'b0;
    endtask

    // Address on the rising edge, data taken mid cycle
    task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
        @(posedge clk);
        raddr_i <= a;
        @(negedge clk);
        d = rdata_o;
    endtask

    task automatic check_value(input int idx, input logic [31:0] value);
        assert ((value & mask_q[idx]) == exp_q[idx]) else begin
            $display("[FAIL] %s expected %h actual %h", name_q[idx], exp_q[idx],
                     value & mask_q[idx]);
            row_ok = 1'b0;
        end
    endtask

    // Status, Cause, EPC and EBase also leave on their own ports
    task automatic check_direct(input int idx);
        logic [31:0] value;
        logic        mapped;
        mapped = 1'b1;
        value  = '0;
        case (addr_q[idx])
            ADDR_STATUS: value = status_o;
            ADDR_CAUSE:  value = cause_o;
            ADDR_EPC:    value = epc_o;
            ADDR_EBASE:  value = ebase_o;
            default:     mapped = 1'b0;
        endcase
        if (mapped) begin
            assert ((value & mask_q[idx]) == exp_q[idx]) else begin
                $display("[FAIL] %s output port expected %h actual %h", name_q[idx],
                         exp_q[idx], value & mask_q[idx]);
                row_ok = 1'b0;
            end
        end
    endtask

    task automatic poll_reg(input int idx);
        logic [31:0] value;
        int          cycles;
        cycles = 0;
        read_reg(addr_q[idx], value);
        while (((value & mask_q[idx]) != exp_q[idx]) && (cycles < POLL_LIMIT)) begin
            read_reg(addr_q[idx], value);
            cycles++;
        end
        assert ((value & mask_q[idx]) == exp_q[idx]) else begin
            $display("[TIMEOUT] %s: register did not reach %h within %0d cycles",
                     name_q[idx], exp_q[idx], POLL_LIMIT);
            row_ok = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------
    // Table contents
    // ------------------------------------------------------------------
    task automatic build_table();
        // Reset values
        add_row("rst_status", OP_RD, ADDR_STATUS, '0, '0, '0, '1, 32'd1 << STATUS_BEV_BIT);
        add_row("rst_cause", OP_RD, ADDR_CAUSE, '0, '0, '0, '1, '0);
        add_row("rst_ebase", OP_RD, ADDR_EBASE, '0, '0, '0, '1, 32'h8000_0000);
        add_row("rst_k0", OP_RD, ADDR_CONFIG0, '0, '0, '0, 32'h7, 32'h3);
        add_row("rst_uncache", OP_UNC, '0, '0, '0, '0, 32'h1, '0);
        add_row("rst_prid", OP_RD, ADDR_PRID, '0, '0, '0, '1, PRID);
        // Write masks
        add_row("wr_status_ones", OP_WR, ADDR_STATUS, '1, '0, '0, '0, '0);
        add_row("rd_status_mask", OP_RD, ADDR_STATUS, '0, '0, '0, '1, 32'h1040_FF13);
        add_row("wr_status_bev", OP_WR, ADDR_STATUS, 32'h0040_0000, '0, '0, '0, '0);
        add_row("wr_ebase_ones", OP_WR, ADDR_EBASE, '1, '0, '0, '0, '0);
        add_row("rd_ebase_mask", OP_RD, ADDR_EBASE, '0, '0, '0, '1, 32'hBFFF_F000);
        add_row("wr_k0_uncached", OP_WR, ADDR_CONFIG0, 32'h2, '0, '0, '0, '0);
        add_row("rd_uncache", OP_UNC, '0, '0, '0, '0, 32'h1, 32'h1);
        // CpU exception outside a delay slot, then return
        add_row("exc_cpu", OP_EXC, '0, 32'h8000_0100, '0, {2'b01, EXC_CPU}, '0, '0);
        add_row("rd_epc_cpu", OP_RD, ADDR_EPC, '0, '0, '0, '1, 32'h8000_0100);
        add_row("rd_cause_cpu", OP_RD, ADDR_CAUSE, '0, '0, '0, 32'hB000_007C,
                32'h1000_0000 | {25'd0, EXC_CPU, 2'b00});
        add_row("rd_exl_cpu", OP_RD, ADDR_STATUS, '0, '0, '0, 32'h2, 32'h2);
        add_row("eret_cpu", OP_EXC, '0, '0, '0, {2'b00, EXC_ERET}, '0, '0);
        add_row("rd_exl_clear", OP_RD, ADDR_STATUS, '0, '0, '0, 32'h2, '0);
        // Address error in a delay slot
        add_row("exc_adel_bd", OP_EXC, '0, 32'h8000_1000, 32'h1234_5678,
                {2'b10, EXC_ADEL}, '0, '0);
        add_row("rd_epc_bd", OP_RD, ADDR_EPC, '0, '0, '0, '1, 32'h8000_0FFC);
        add_row("rd_cause_adel", OP_RD, ADDR_CAUSE, '0, '0, '0, 32'h8000_007C,
                32'h8000_0000 | {25'd0, EXC_ADEL, 2'b00});
        add_row("rd_badv_adel", OP_RD, ADDR_BADVADDR, '0, '0, '0, '1, 32'h1234_5678);
        add_row("rd_exl_adel", OP_RD, ADDR_STATUS, '0, '0, '0, 32'h2, 32'h2);
        // Nested TLBL keeps EPC and ExcCode
        add_row("exc_tlbl_nested", OP_EXC, '0, 32'h8000_2000, 32'hDEAD_B000,
                {2'b00, EXC_TLBL}, '0, '0);
        add_row("rd_epc_nested", OP_RD, ADDR_EPC, '0, '0, '0, '1, 32'h8000_0FFC);
        add_row("rd_cause_nested", OP_RD, ADDR_CAUSE, '0, '0, '0, 32'h8000_007C,
                32'h8000_0000 | {25'd0, EXC_ADEL, 2'b00});
        add_row("rd_badv_nested", OP_RD, ADDR_BADVADDR, '0, '0, '0, '1, 32'hDEAD_B000);
        add_row("eret_nested", OP_EXC, '0, '0, '0, {2'b00, EXC_ERET}, '0, '0);
        add_row("rd_exl_eret", OP_RD, ADDR_STATUS, '0, '0, '0, 32'h2, '0);
        // Timer match, TI and IP7, then ack
        add_row("wr_count", OP_WR, ADDR_COUNT, count_n, '0, '0, '0, '0);
        add_row("wr_compare", OP_WR, ADDR_COMPARE, count_n + 32'd4, '0, '0, '0, '0);
        add_row("poll_timer", OP_POLL, ADDR_CAUSE, '0, '0, '0,
                (32'd1 << CAUSE_TI_BIT) | 32'h8000, (32'd1 << CAUSE_TI_BIT) | 32'h8000);
        add_row("wr_compare_ack", OP_WR, ADDR_COMPARE, count_n, '0, '0, '0, '0);
        add_row("rd_ti_clear", OP_RD, ADDR_CAUSE, '0, '0, '0, 32'd1 << CAUSE_TI_BIT, '0);
        // Hardware lines 4..0 into IP6..2
        add_row("int_pattern", OP_INT, '0, 32'h16, '0, '0, '0, '0);
        add_row("rd_cause_int", OP_RD, ADDR_CAUSE, '0, '0, '0, 32'h7C00, 32'h5800);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        arst_n_i      = 1'b0;
        int_i         = '0;
        we_i          = 1'b0;
        waddr_i       = '0;
        wdata_i       = '0;
        exc_valid_i   = 1'b0;
        exc_code_i    = '0;
        exc_pc_i      = '0;
        exc_badaddr_i = '0;
        exc_bd_i      = 1'b0;
        exc_cpux_i    = 1'b0;
        raddr_i       = '0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        seed          = 32'hc33c;
        count_n       = $random(seed);
        build_table();
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int i = 0; i < name_q.size(); i++) begin
            row_ok = 1'b1;
            case (op_q[i])
                OP_WR:   write_reg(addr_q[i], data_q[i]);
                OP_EXC:  raise_exc(i);
                OP_POLL: poll_reg(i);
                OP_INT: begin
                    @(posedge clk);
                    int_i <= data_q[i][5:0];
                end
                OP_UNC: begin
                    @(posedge clk);
                    @(negedge clk);
                    check_value(i, {31'd0, uncache_o});
                end
                default: begin
                    read_reg(addr_q[i], got);
                    check_value(i, got);
                    check_direct(i);
                end
            endcase
            if (row_ok) begin
                pass_cnt++;
                $display("[PASS] %s", name_q[i]);
            end else begin
                fail_cnt++;
            end
        end
        $display("Tests: %0d, passed: %0d, failed: %0d", name_q.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/cp0_addr_pkg.sv
verilog/cp0_exc_pkg.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/cp0_read_mux.sv
verilog/cp0_top.sv
sim/cp0_props.sv
sim/tb_cp0.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CP0 testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cp0 -f all.f -o tb_cp0 \
    && ./obj_dir/tb_cp0 > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
